//--- verilog/keypad_pkg.sv
package keypad_pkg;

    // Keypad geometry
    localparam int ROW_COUNT = 4;
    localparam int COL_COUNT = 4;
    localparam int KEY_COUNT = ROW_COUNT * COL_COUNT;

    // Timing at 100 MHz
    localparam int SCAN_DWELL_CYCLES = 1000;  // Per row, one frame is 4000 cycles
    localparam int DEBOUNCE_FRAMES   = 4;
    localparam int BAUD_DIVISOR      = 868;   // About 115200 baud
    localparam int TX_FIFO_DEPTH     = 4;
    localparam int UART_FRAME_BITS   = 10;    // Start, 8 data, stop

    // Counter widths derived from the above
    localparam int DWELL_CNT_W    = $clog2(SCAN_DWELL_CYCLES);
    localparam int ROW_PTR_W      = $clog2(ROW_COUNT);
    localparam int DEBOUNCE_CNT_W = $clog2(DEBOUNCE_FRAMES);
    localparam int BAUD_CNT_W     = $clog2(BAUD_DIVISOR);
    localparam int BIT_IDX_W      = $clog2(UART_FRAME_BITS);
    localparam int FIFO_PTR_W     = $clog2(TX_FIFO_DEPTH);
    localparam int DEPTH_CNT_W    = $clog2(TX_FIFO_DEPTH + 1);  // Holds 0 to depth

    // Key number, row * 4 + column
    typedef logic [$clog2(KEY_COUNT)-1:0] key_index_t;

    // Snapshot of one complete scan
    typedef struct packed {
        logic                 frame_done;
        logic [KEY_COUNT-1:0] raw;
    } scan_frame_t;

    // One character towards the UART
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } tx_char_t;

endpackage

//--- verilog/keypad_scanner.sv
`timescale 1ns/1ns

module keypad_scanner import keypad_pkg::*; (
    input  logic                 CLK_100MHz,
    input  logic                 rst_n,
    input  logic [COL_COUNT-1:0] keypad_cols,
    output logic [ROW_COUNT-1:0] keypad_rows,
    output scan_frame_t          scan_frame
);

    logic [DWELL_CNT_W-1:0] dwell_cnt;
    logic [ROW_PTR_W-1:0]   row_ptr;
    logic                   last_dwell;
    logic                   last_row;

    logic [COL_COUNT-1:0]   cols_meta;
    logic [COL_COUNT-1:0]   cols_sync;

    logic [KEY_COUNT-1:0]   work_q;      // Rows sampled so far in this frame
    logic [KEY_COUNT-1:0]   frame_next;
    logic [KEY_COUNT-1:0]   raw_q;
    logic                   frame_done_q;

    assign last_dwell  = (dwell_cnt == DWELL_CNT_W'(SCAN_DWELL_CYCLES - 1));
    assign last_row    = (row_ptr == ROW_PTR_W'(ROW_COUNT - 1));
    assign keypad_rows = ROW_COUNT'(1) << row_ptr;  // One-hot, active high

    // Dwell counter and row pointer
    always_ff @(posedge CLK_100MHz or negedge rst_n) begin
        if (!rst_n) begin
            dwell_cnt <= '0;
            row_ptr   <= '0;
        end else if (last_dwell) begin
            dwell_cnt <= '0;
            row_ptr   <= row_ptr + 1'b1;  // Wraps from row 3 back to row 0
        end else begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    // Two-flop synchroniser on the column inputs
    always_ff @(posedge CLK_100MHz) begin
        cols_meta <= keypad_cols;
        cols_sync <= cols_meta;
    end

    // Current row's columns merged into the working vector
    always_comb begin
        frame_next = work_q;
        frame_next[row_ptr*COL_COUNT +: COL_COUNT] = cols_sync;
    end

    always_ff @(posedge CLK_100MHz) begin
        if (last_dwell) begin
            work_q <= frame_next;
            if (last_row) raw_q <= frame_next;  // Snapshot held until next frame
        end
    end

    always_ff @(posedge CLK_100MHz or negedge rst_n) begin
        if (!rst_n) begin
            frame_done_q <= 1'b0;
        end else begin
            frame_done_q <= last_dwell && last_row;
        end
    end

    assign scan_frame = '{frame_done: frame_done_q, raw: raw_q};

endmodule

//--- verilog/key_debounce.sv
`timescale 1ns/1ns

module key_debounce import keypad_pkg::*; (
    input  logic CLK_100MHz,
    input  logic rst_n,
    input  logic frame_done,
    input  logic raw,
    output logic press_event
);

    logic                      stable;    // Debounced key state
    logic [DEBOUNCE_CNT_W-1:0] diff_cnt;  // Consecutive frames disagreeing with stable

    always_ff @(posedge CLK_100MHz or negedge rst_n) begin
        if (!rst_n) begin
            stable      <= 1'b0;
            diff_cnt    <= '0;
            press_event <= 1'b0;
        end else begin
            press_event <= 1'b0;
            if (frame_done) begin
                if (raw == stable) begin
                    diff_cnt <= '0;  // Glitch ended, start over
                end else if (diff_cnt == DEBOUNCE_CNT_W'(DEBOUNCE_FRAMES - 1)) begin
                    stable      <= raw;
                    diff_cnt    <= '0;
                    press_event <= raw;  // Only released to pressed
                end else begin
                    diff_cnt <= diff_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- verilog/key_event_arbiter.sv
`timescale 1ns/1ns

module key_event_arbiter import keypad_pkg::*; (
    input  logic                 CLK_100MHz,
    input  logic                 rst_n,
    input  logic [KEY_COUNT-1:0] press_event,
    input  logic                 credit_return,
    output tx_char_t             tx_char,
    output logic [3:0]           leds
);

    logic [KEY_COUNT-1:0]   pending;
    logic [DEPTH_CNT_W-1:0] credits;
    key_index_t             sel_idx;
    logic                   send;
    logic                   tx_valid_q;
    logic [7:0]             tx_data_q;

    // ASCII map of the keypad legend
    function automatic logic [7:0] key_to_ascii(key_index_t idx);
        logic [7:0] code;
        if (idx <= key_index_t'(9)) begin
            code = 8'h30 + {4'd0, idx};          // '0' to '9'
        end else if (idx <= key_index_t'(13)) begin
            code = 8'h41 + {4'd0, idx - 4'd10};  // 'A' to 'D'
        end else if (idx == key_index_t'(14)) begin
            code = 8'h2A;  // '*'
        end else begin
            code = 8'h23;  // '#'
        end
        return code;
    endfunction

    // Lowest pending index wins
    always_comb begin
        sel_idx = '0;
        for (int i = KEY_COUNT - 1; i >= 0; i--) begin
            if (pending[i]) sel_idx = key_index_t'(i);
        end
    end

    assign send = (credits != '0) && (pending != '0);

    always_ff @(posedge CLK_100MHz or negedge rst_n) begin
        if (!rst_n) begin
            pending    <= '0;
            credits    <= DEPTH_CNT_W'(TX_FIFO_DEPTH);
            tx_valid_q <= 1'b0;
            leds       <= '0;
        end else begin
            // New events OR'd in after the clear so a fresh press is kept
            if (send) begin
                pending <= (pending & ~(KEY_COUNT'(1) << sel_idx)) | press_event;
                leds    <= sel_idx;
            end else begin
                pending <= pending | press_event;
            end

            case ({send, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;  // Both or neither
            endcase

            tx_valid_q <= send;
        end
    end

    always_ff @(posedge CLK_100MHz) begin
        if (send) tx_data_q <= key_to_ascii(sel_idx);
    end

    assign tx_char = '{valid: tx_valid_q, data: tx_data_q};

endmodule

//--- verilog/uart_transmitter.sv
`timescale 1ns/1ns

module uart_transmitter import keypad_pkg::*; (
    input  logic     CLK_100MHz,
    input  logic     rst_n,
    input  tx_char_t tx_char,
    output logic     credit_return,
    output logic     uart_tx
);

    logic [7:0]             fifo_mem [TX_FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0]  wr_ptr;
    logic [FIFO_PTR_W-1:0]  rd_ptr;
    logic [DEPTH_CNT_W-1:0] fifo_count;

    logic                   busy;
    logic [BAUD_CNT_W-1:0]  baud_cnt;
    logic [BIT_IDX_W-1:0]   bit_idx;   // 0 is the start bit, last is the stop bit
    logic [8:0]             shift_q;   // Stop bit above the data byte
    logic                   baud_tick;
    logic                   frame_end;
    logic                   pop;

    assign baud_tick = busy && (baud_cnt == BAUD_CNT_W'(BAUD_DIVISOR - 1));
    assign frame_end = baud_tick && (bit_idx == BIT_IDX_W'(UART_FRAME_BITS - 1));

    // Pop on the last stop-bit cycle too, so queued bytes run back to back
    assign pop = (!busy || frame_end) && (fifo_count != '0);

    always_ff @(posedge CLK_100MHz) begin
        if (tx_char.valid) fifo_mem[wr_ptr] <= tx_char.data;
    end

    // Buffer pointers and credit return
    always_ff @(posedge CLK_100MHz or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            fifo_count    <= '0;
            credit_return <= 1'b0;
        end else begin
            if (tx_char.valid) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            credit_return <= pop;  // One credit per popped byte

            case ({tx_char.valid, pop})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

    // Bit timing and line drive
    always_ff @(posedge CLK_100MHz or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
            uart_tx  <= 1'b1;  // Idle high
        end else if (pop) begin
            busy     <= 1'b1;
            baud_cnt <= '0;
            bit_idx  <= '0;
            uart_tx  <= 1'b0;  // Start bit
        end else if (busy) begin
            if (baud_tick) begin
                baud_cnt <= '0;
                if (frame_end) begin
                    busy <= 1'b0;
                end else begin
                    uart_tx <= shift_q[0];
                    bit_idx <= bit_idx + 1'b1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    // Data shifter, LSB first
    always_ff @(posedge CLK_100MHz) begin
        if (pop) begin
            shift_q <= {1'b1, fifo_mem[rd_ptr]};
        end else if (baud_tick && !frame_end) begin
            shift_q <= {1'b1, shift_q[8:1]};
        end
    end

endmodule

//--- verilog/keypad_uart_top.sv
`timescale 1ns/1ns

module keypad_uart_top import keypad_pkg::*; (
    input  logic                 CLK_100MHz,
    input  logic                 rst_n,
    input  logic [COL_COUNT-1:0] keypad_cols,
    output logic [ROW_COUNT-1:0] keypad_rows,
    output logic [3:0]           leds,
    output logic                 uart_tx
);

    scan_frame_t          scan_frame;
    logic [KEY_COUNT-1:0] press_event;
    tx_char_t             tx_char;
    logic                 credit_return;

    keypad_scanner u_scanner (
        .CLK_100MHz  (CLK_100MHz),
        .rst_n       (rst_n),
        .keypad_cols (keypad_cols),
        .keypad_rows (keypad_rows),
        .scan_frame  (scan_frame)
    );

    // One debouncer per key
    for (genvar k = 0; k < KEY_COUNT; k++) begin : g_debounce
        key_debounce u_debounce (
            .CLK_100MHz  (CLK_100MHz),
            .rst_n       (rst_n),
            .frame_done  (scan_frame.frame_done),
            .raw         (scan_frame.raw[k]),
            .press_event (press_event[k])
        );
    end

    key_event_arbiter u_arbiter (
        .CLK_100MHz    (CLK_100MHz),
        .rst_n         (rst_n),
        .press_event   (press_event),
        .credit_return (credit_return),
        .tx_char       (tx_char),
        .leds          (leds)
    );

    uart_transmitter u_transmitter (
        .CLK_100MHz    (CLK_100MHz),
        .rst_n         (rst_n),
        .tx_char       (tx_char),
        .credit_return (credit_return),
        .uart_tx       (uart_tx)
    );

endmodule

//--- dv/keypad_assertions.sv
`timescale 1ns/1ns

module keypad_assertions import keypad_pkg::*; (
    input logic                   CLK_100MHz,
    input logic                   rst_n,
    input logic [ROW_COUNT-1:0]   keypad_rows,
    input logic                   char_valid,
    input logic                   credit_return,
    input logic [DEPTH_CNT_W-1:0] credits
);

    int fail_count = 0;

    // Characters issued and not yet popped by the transmitter
    logic [DEPTH_CNT_W-1:0] outstanding;

    always_ff @(posedge CLK_100MHz or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= '0;
        end else begin
            case ({char_valid, credit_return})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    rows_one_hot: assert property (@(posedge CLK_100MHz) disable iff (!rst_n)
        $onehot(keypad_rows))
    else begin
        $error("keypad_rows is not one-hot: %b", keypad_rows);
        fail_count++;
    end

    // A new character needs a free FIFO slot, seen from the interface
    valid_needs_credit: assert property (@(posedge CLK_100MHz) disable iff (!rst_n)
        char_valid |-> outstanding < DEPTH_CNT_W'(TX_FIFO_DEPTH))
    else begin
        $error("Character issued with no credit");
        fail_count++;
    end

    credits_bounded: assert property (@(posedge CLK_100MHz) disable iff (!rst_n)
        credits <= DEPTH_CNT_W'(TX_FIFO_DEPTH))
    else begin
        $error("Credit count %0d above FIFO depth", credits);
        fail_count++;
    end

endmodule

bind keypad_uart_top keypad_assertions u_assert (
    .CLK_100MHz    (CLK_100MHz),
    .rst_n         (rst_n),
    .keypad_rows   (keypad_rows),
    .char_valid    (tx_char.valid),
    .credit_return (credit_return),
    .credits       (u_arbiter.credits)
);

//--- include/expected_char.svh
`ifndef EXPECTED_CHAR_SVH
`define EXPECTED_CHAR_SVH

// One character the monitor should see, with the key that produced it
typedef struct packed {
    logic [3:0] index;
    logic [7:0] code;
} expected_char_t;

`endif

//--- dv/uart_monitor.sv
`timescale 1ns/1ns
`include "expected_char.svh"

module uart_monitor import keypad_pkg::*; (
    input  logic           CLK_100MHz,
    input  logic           rst_n,
    input  logic           uart_tx,
    input  logic [3:0]     leds,
    input  logic           char_valid,
    input  logic           exp_push,
    input  expected_char_t exp_entry,
    input  logic           end_check,
    output int             queue_level,
    output logic           rx_busy,
    output int             value_errors,
    output int             other_errors
);

    expected_char_t exp_q [$];
    int             in_flight;  // Issued by the arbiter, not yet off the line
    int             wait_cnt;
    int             bit_n;      // 0 start, 1 to 8 data, 9 stop
    logic           prev_tx;
    logic           started;
    logic           leds_reported;
    logic [7:0]     rx_byte;

    task compare_byte();
        if (exp_q.size() == 0) begin
            other_errors++;
            $display("Extra character 0x%h on uart_tx with none expected", rx_byte);
        end else begin
            if (rx_byte !== exp_q[0].code) begin
                value_errors++;
                $display("CHECK FAILED uart_tx: expected 0x%h, got 0x%h", exp_q[0].code, rx_byte);
            end
            void'(exp_q.pop_front());
            if (in_flight > 0) in_flight--;
        end
    endtask

    always @(negedge CLK_100MHz) begin
        if (!rst_n) begin
            exp_q.delete();
            in_flight     = 0;
            rx_busy       = 1'b0;
            prev_tx       = 1'b1;
            started       = 1'b0;
            leds_reported = 1'b0;
            value_errors  = 0;
            other_errors  = 0;
            queue_level   = 0;
        end else begin
            if (exp_push) exp_q.push_back(exp_entry);

            // leds show the index of each character as the arbiter issues it
            if (char_valid) begin
                started = 1'b1;
                if (in_flight >= exp_q.size()) begin
                    other_errors++;
                    $display("Arbiter issued a character that was not expected at %0t", $time);
                end else begin
                    if (leds !== exp_q[in_flight].index) begin
                        value_errors++;
                        $display("CHECK FAILED leds: expected 0x%h, got 0x%h",
                                 exp_q[in_flight].index, leds);
                    end
                    in_flight++;
                end
            end else if (!started && leds !== 4'h0 && !leds_reported) begin
                leds_reported = 1'b1;
                value_errors++;
                $display("CHECK FAILED leds: expected 0x0, got 0x%h", leds);
            end

            // Serial decoder, samples each bit near its middle
            if (!rx_busy) begin
                if (prev_tx && !uart_tx) begin  // Falling start bit
                    rx_busy  = 1'b1;
                    wait_cnt = BAUD_DIVISOR / 2;
                    bit_n    = 0;
                end
            end else if (wait_cnt != 0) begin
                wait_cnt--;
            end else begin
                wait_cnt = BAUD_DIVISOR - 1;
                if (bit_n == 0 && uart_tx !== 1'b0) begin
                    other_errors++;
                    rx_busy = 1'b0;
                    $display("Start bit on uart_tx did not stay low at %0t", $time);
                end else if (bit_n >= 1 && bit_n <= 8) begin
                    rx_byte = {uart_tx, rx_byte[7:1]};  // LSB first
                end else if (bit_n == 9) begin
                    rx_busy = 1'b0;
                    if (uart_tx !== 1'b1) begin
                        other_errors++;
                        $display("Stop bit on uart_tx was not high at %0t", $time);
                    end
                    compare_byte();
                end
                bit_n++;
            end

            if (end_check) begin
                if (uart_tx !== 1'b1) begin
                    other_errors++;
                    $display("The uart_tx line is not idle high at the end of the run");
                end
                if (exp_q.size() != 0) begin
                    other_errors++;
                    $display("%0d expected characters never arrived on uart_tx", exp_q.size());
                end
            end

            prev_tx     = uart_tx;
            queue_level = exp_q.size();
        end
    end

endmodule

//--- dv/tb_top.sv
`timescale 1ns/1ns
`include "expected_char.svh"

module tb_top import keypad_pkg::*; ();

    // One stimulus row, the expected characters follow from the mask
    typedef struct packed {
        logic [KEY_COUNT-1:0] key_mask;
        logic [31:0]          hold_cycles;
        logic [31:0]          release_cycles;
        logic                 expect_chars;
    } stim_row_t;

    localparam int STIM_ROWS     = 21;
    localparam int DRAIN_TIMEOUT = 200000;  // Cycles
    localparam int FRAME_TIMEOUT = 2 * ROW_COUNT * SCAN_DWELL_CYCLES;

    logic                 CLK_100MHz = 1'b0;
    logic                 rst_n;
    logic [COL_COUNT-1:0] keypad_cols;
    logic [ROW_COUNT-1:0] keypad_rows;
    logic [3:0]           leds;
    logic                 uart_tx;

    logic [KEY_COUNT-1:0] pressed;  // Keypad model state
    logic                 exp_push;
    expected_char_t       exp_entry;
    logic                 end_check;
    int                   queue_level;
    logic                 rx_busy;
    int                   value_errors;
    int                   other_errors;
    int                   timeout_errors;
    stim_row_t            stim_table [STIM_ROWS];

    always #5 CLK_100MHz = ~CLK_100MHz;

    keypad_uart_top DUT (
        .CLK_100MHz  (CLK_100MHz),
        .rst_n       (rst_n),
        .keypad_cols (keypad_cols),
        .keypad_rows (keypad_rows),
        .leds        (leds),
        .uart_tx     (uart_tx)
    );

    uart_monitor u_monitor (
        .CLK_100MHz   (CLK_100MHz),
        .rst_n        (rst_n),
        .uart_tx      (uart_tx),
        .leds         (leds),
        .char_valid   (DUT.tx_char.valid),
        .exp_push     (exp_push),
        .exp_entry    (exp_entry),
        .end_check    (end_check),
        .queue_level  (queue_level),
        .rx_busy      (rx_busy),
        .value_errors (value_errors),
        .other_errors (other_errors)
    );

    // Columns show the pressed keys of whichever row is driven
    always_comb begin
        keypad_cols = '0;
        for (int r = 0; r < ROW_COUNT; r++) begin
            if (keypad_rows[r]) keypad_cols = keypad_cols | pressed[r*COL_COUNT +: COL_COUNT];
        end
    end

    // Keypad legend in key index order
    function automatic logic [7:0] legend_char(int idx);
        string legend;
        legend = "0123456789ABCD*#";
        return legend[idx];
    endfunction

    task automatic fill_table();
        stim_table[0] = '{16'h0000, 32'd20000, 32'd0, 1'b0};  // Quiet line after reset
        for (int k = 0; k < KEY_COUNT; k++) begin
            stim_table[1 + k] = '{KEY_COUNT'(1 << k), 32'd40000, 32'd40000, 1'b1};
        end
        stim_table[17] = '{16'h0080, 32'd3000, 32'd40000, 1'b0};    // Shorter than a frame
        stim_table[18] = '{16'h0020, 32'd200000, 32'd40000, 1'b1};  // Long hold
        stim_table[19] = '{16'h0020, 32'd40000, 32'd40000, 1'b1};   // Same key again
        stim_table[20] = '{16'h9A5A, 32'd40000, 32'd80000, 1'b1};   // Eight at once
    endtask

    // First cycle of row 0, so keys pressed together land in one scan frame
    task automatic wait_frame_start();
        int cycles;
        cycles = 0;
        while (keypad_rows[0] && cycles < FRAME_TIMEOUT) begin
            @(posedge CLK_100MHz);
            cycles++;
        end
        while (!keypad_rows[0] && cycles < FRAME_TIMEOUT) begin
            @(posedge CLK_100MHz);
            cycles++;
        end
        if (cycles >= FRAME_TIMEOUT) begin
            timeout_errors++;
            $display("Timed out waiting for the keypad scan to reach row 0");
        end
    endtask

    // Queue expected characters lowest index first, then press and release
    task automatic apply_row(input stim_row_t row);
        if (row.expect_chars) begin
            for (int k = 0; k < KEY_COUNT; k++) begin
                if (row.key_mask[k]) begin
                    @(posedge CLK_100MHz);
                    exp_push  <= 1'b1;
                    exp_entry <= '{index: 4'(k), code: legend_char(k)};
                end
            end
            @(posedge CLK_100MHz);
            exp_push <= 1'b0;
        end
        wait_frame_start();
        pressed <= row.key_mask;
        repeat (row.hold_cycles) @(posedge CLK_100MHz);
        pressed <= '0;
        repeat (row.release_cycles) @(posedge CLK_100MHz);
    endtask

    initial begin
        int drain_cnt;
        int total;
        rst_n          = 1'b0;
        pressed        = '0;
        exp_push       = 1'b0;
        exp_entry      = '0;
        end_check      = 1'b0;
        timeout_errors = 0;
        fill_table();
        repeat (10) @(posedge CLK_100MHz);
        rst_n <= 1'b1;

        for (int i = 0; i < STIM_ROWS; i++) begin
            apply_row(stim_table[i]);
        end

        drain_cnt = 0;
        while ((queue_level != 0 || rx_busy) && drain_cnt < DRAIN_TIMEOUT) begin
            @(posedge CLK_100MHz);
            drain_cnt++;
        end
        if (queue_level != 0 || rx_busy) begin
            timeout_errors++;
            $display("Timed out waiting for the expected characters on uart_tx");
        end

        @(posedge CLK_100MHz);
        end_check <= 1'b1;  // Monitor checks idle line and empty queue
        @(posedge CLK_100MHz);
        end_check <= 1'b0;
        @(posedge CLK_100MHz);

        total = value_errors + other_errors + timeout_errors + DUT.u_assert.fail_count;
        $display("Errors: %0d value mismatch, %0d missing or extra, %0d timeout, %0d assertion",
                 value_errors, other_errors, timeout_errors, DUT.u_assert.fail_count);
        if (total == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+include
verilog/keypad_pkg.sv
verilog/keypad_scanner.sv
verilog/key_debounce.sv
verilog/key_event_arbiter.sv
verilog/uart_transmitter.sv
verilog/keypad_uart_top.sv
dv/keypad_assertions.sv
dv/uart_monitor.sv
dv/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the keypad UART testbench with Verilator

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -f tb.f --top-module tb_top \
    --Mdir "$BUILD_DIR" -o tb_top_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_top_sim" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0
